// ==== source/control_pkg.sv ====
`default_nettype none

package control_pkg;

    // ==================================================
    // Widths that carry a meaning
    // ==================================================

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [4:0]  shift_amt_t;
    typedef logic [23:0] imm24_t;
    typedef logic [1:0]  step_t;
    typedef logic [3:0]  alu_op_t;

    localparam reg_idx_t PC_REG = 4'd15;

    // ARM data-processing opcodes used by the sequencer itself
    localparam alu_op_t ALU_SUB = 4'd2;
    localparam alu_op_t ALU_ADD = 4'd4;
    localparam alu_op_t ALU_MOV = 4'd13;

    // ==================================================
    // Enumerations
    // ==================================================

    typedef enum logic [2:0] {
        DP_IMM,
        DP_REG_IMM,
        DP_REG_REG,
        LOAD,
        STORE,
        BRANCH,
        BRANCH_LINK,
        UNDEFINED
    } instr_class_t;

    typedef enum logic [1:0] {
        FLUSH_ADDR,
        FLUSH_FETCH,
        FLUSH_ADVANCE,
        RUN
    } flush_phase_t;

    typedef enum logic [1:0] {ADDR_PC, ADDR_INCR, ADDR_ALU} addr_src_t;

    typedef enum logic {A_NONE, A_RN} a_src_t;

    typedef enum logic [2:0] {
        B_NONE,
        B_IMM,
        B_RM,
        B_RS,
        B_RD,
        B_READ_DATA
    } b_src_t;

    // Same encoding as bits 6:5 of the instruction
    typedef enum logic [1:0] {LSL, LSR, ASR, ROR} shift_type_t;

    typedef enum logic [1:0] {WB_NONE, WB_RD, WB_RN, WB_R14} alu_wb_t;

    // ==================================================
    // Decoded fields and the datapath control word
    // ==================================================

    typedef struct packed {
        instr_class_t instr_class;
        reg_idx_t     rn;
        reg_idx_t     rm;
        alu_op_t      alu_op;
        logic         set_flags;
        shift_type_t  shift_type;
        shift_amt_t   shift_amt;
        logic [7:0]   imm8;
        logic [3:0]   rotate;
        logic [11:0]  imm12;
        logic         i;    // Transfer offset is a shifted register
        logic         p;
        logic         u;
        logic         b;
        logic         w;
        imm24_t       imm24;
    } decoded_t;

    typedef struct packed {
        addr_src_t   addr_src;
        logic        instr_fetch;
        logic        incr_writeback;
        logic        pipeline_advance;
        a_src_t      a_src;
        b_src_t      b_src;
        imm24_t      b_imm;
        logic        b_sign_extend;
        shift_type_t shift_type;
        shift_amt_t  shift_amt;
        logic        shift_latch_amt;
        logic        shift_use_latch;
        logic        shift_use_rrx;
        alu_op_t     alu_op;
        alu_wb_t     alu_wb;
        logic        set_flags;
        logic        alu_latch_op_b;
        logic        alu_use_op_b_latch;
        logic        alu_disable_op_b;
        logic        pc_rn_add_4;
        logic        pc_rm_add_4;
        logic        mem_read;
        logic        mem_write;
        logic        mem_byte;
    } control_t;

    // Fetch the next word from the PC and write PC + 4 back
    function automatic control_t fetch_word();
        control_t c;
        c = '0;
        c.addr_src = ADDR_PC;
        c.instr_fetch = 1'b1;
        c.incr_writeback = 1'b1;
        return c;
    endfunction

endpackage

`default_nettype wire

// ==== source/instr_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_classifier (
    input  control_pkg::word_t    instr,
    output control_pkg::decoded_t decoded
);

    import control_pkg::*;

    instr_class_t instr_class;

    // Class from the major opcode bits
    always_comb begin
        instr_class = UNDEFINED;
        if (instr[27:26] == 2'b00) begin
            if (instr[25]) begin
                instr_class = DP_IMM;
            end else if (!instr[4]) begin
                instr_class = DP_REG_IMM;
            end else if (!instr[7]) begin
                instr_class = DP_REG_REG;
            end
        end else if (instr[27:26] == 2'b01) begin
            instr_class = instr[20] ? LOAD : STORE;
        end else if (instr[27:25] == 3'b101) begin
            instr_class = instr[24] ? BRANCH_LINK : BRANCH;
        end
    end

    always_comb begin
        decoded.instr_class = instr_class;

        // A branch has no base field, its base is the PC
        if (instr_class == BRANCH || instr_class == BRANCH_LINK) begin
            decoded.rn = PC_REG;
        end else begin
            decoded.rn = instr[19:16];
        end
        decoded.rm = instr[3:0];

        decoded.alu_op     = instr[24:21];
        decoded.set_flags  = instr[20];
        decoded.shift_type = shift_type_t'(instr[6:5]);
        decoded.shift_amt  = instr[11:7];

        decoded.imm8   = instr[7:0];
        decoded.rotate = instr[11:8];
        decoded.imm12  = instr[11:0];

        // Single transfer flag bits
        decoded.i = instr[25];
        decoded.p = instr[24];
        decoded.u = instr[23];
        decoded.b = instr[22];
        decoded.w = instr[21];

        decoded.imm24 = instr[23:0];
    end

endmodule

`default_nettype wire

// ==== source/step_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush_req,
    input  logic                      pipeline_advance,
    output control_pkg::flush_phase_t phase,
    output control_pkg::step_t        step
);

    import control_pkg::*;

    logic [1:0] flush_cnt;

    // 3 after reset, 1 after a flush request, then down to 0
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_cnt <= 2'd3;
        end else if (flush_req) begin
            flush_cnt <= 2'd1;
        end else if (flush_cnt != 2'd0) begin
            flush_cnt <= flush_cnt - 2'd1;
        end
    end

    always_comb begin
        if (flush_req) begin
            phase = FLUSH_FETCH;
        end else begin
            case (flush_cnt)
                2'd3:    phase = FLUSH_ADDR;
                2'd2:    phase = FLUSH_FETCH;
                2'd1:    phase = FLUSH_ADVANCE;
                default: phase = RUN;
            endcase
        end
    end

    // Step within the current instruction, held at 2 by a word that never ends
    always_ff @(posedge clk) begin
        if (reset || pipeline_advance) begin
            step <= 2'd0;
        end else if (step != 2'd2) begin
            step <= step + 2'd1;
        end
    end

    a_step_in_range: assert property (@(posedge clk) disable iff (reset)
        (phase == RUN) |-> (step <= 2'd2));

    a_flush_done: assert property (@(posedge clk)
        $fell(reset) |-> ##[1:3] (flush_cnt == 2'd0));

endmodule

`default_nettype wire

// ==== source/dataproc_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataproc_control (
    input  control_pkg::decoded_t decoded,
    input  control_pkg::step_t    step,
    output control_pkg::control_t control
);

    import control_pkg::*;

    logic is_compare;

    // TST, TEQ, CMP and CMN only update the flags
    assign is_compare = (decoded.alu_op[3:2] == 2'b10);

    always_comb begin
        control = '0;
        case (decoded.instr_class)
            DP_IMM: begin
                control = fetch_word();
                control.pipeline_advance = 1'b1;
                control.b_src = B_IMM;
                control.b_imm = imm24_t'(decoded.imm8);
                control.shift_type = ROR;
                control.shift_amt = {decoded.rotate, 1'b0};
            end

            DP_REG_IMM: begin
                control = fetch_word();
                control.pipeline_advance = 1'b1;
                control.b_src = B_RM;
                control.shift_type = decoded.shift_type;
                control.shift_amt = decoded.shift_amt;
                // ROR #0 encodes RRX
                if (decoded.shift_type == ROR && decoded.shift_amt == 5'd0) begin
                    control.shift_use_rrx = 1'b1;
                end
            end

            DP_REG_REG: begin
                if (step == 2'd0) begin
                    // Internal cycle to latch the amount from Rs
                    control.b_src = B_RS;
                    control.shift_latch_amt = 1'b1;
                end else if (step == 2'd1) begin
                    control = fetch_word();
                    control.pipeline_advance = 1'b1;
                    control.b_src = B_RM;
                    control.shift_type = decoded.shift_type;
                    control.shift_use_latch = 1'b1;
                    // PC reads one word further ahead in this form
                    control.pc_rn_add_4 = (decoded.rn == PC_REG);
                    control.pc_rm_add_4 = (decoded.rm == PC_REG);
                end
            end

            default: ;
        endcase

        // The ALU works on the step that ends the instruction
        if (control.pipeline_advance) begin
            control.alu_op = decoded.alu_op;
            control.alu_wb = is_compare ? WB_NONE : WB_RD;
            control.set_flags = decoded.set_flags;
        end
    end

endmodule

`default_nettype wire

// ==== source/transfer_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module transfer_control (
    input  control_pkg::decoded_t decoded,
    input  control_pkg::step_t    step,
    output control_pkg::control_t control
);

    import control_pkg::*;

    logic    is_transfer;
    logic    base_writeback;
    alu_op_t offset_op;

    assign is_transfer = (decoded.instr_class == LOAD) || (decoded.instr_class == STORE);

    // Post-indexing always updates the base, pre-indexing only with W
    assign base_writeback = !decoded.p || decoded.w;

    assign offset_op = decoded.u ? ALU_ADD : ALU_SUB;

    always_comb begin
        control = '0;
        if (is_transfer && step == 2'd0) begin
            // ==================================================
            // Address step, prefetch while the ALU forms the address
            // ==================================================
            control = fetch_word();
            control.addr_src = ADDR_ALU;
            control.alu_op = offset_op;

            if (!decoded.p) begin
                // Base goes out unmodified, offset kept for writeback
                control.alu_disable_op_b = 1'b1;
                control.alu_latch_op_b = 1'b1;
            end else if (decoded.w) begin
                control.alu_latch_op_b = 1'b1;
            end

            if (decoded.i) begin
                control.b_src = B_RM;
                control.shift_type = decoded.shift_type;
                control.shift_amt = decoded.shift_amt;
                if (decoded.shift_type == ROR && decoded.shift_amt == 5'd0) begin
                    control.shift_use_rrx = 1'b1;
                end
            end else begin
                control.b_src = B_IMM;
                control.b_imm = imm24_t'(decoded.imm12);
            end
        end else if (is_transfer && step == 2'd1) begin
            // ==================================================
            // Memory step
            // ==================================================
            if (decoded.instr_class == LOAD) begin
                control.mem_read = 1'b1;
            end else begin
                control = fetch_word();
                control.pipeline_advance = 1'b1;
                control.b_src = B_RD;
                control.mem_write = 1'b1;
            end
            control.addr_src = ADDR_PC;
            control.alu_op = offset_op;
            control.mem_byte = decoded.b;
            if (base_writeback) begin
                control.alu_use_op_b_latch = 1'b1;
                control.alu_wb = WB_RN;
            end
        end else if (decoded.instr_class == LOAD && step == 2'd2) begin
            // Read data passes through the ALU into Rd
            control = fetch_word();
            control.pipeline_advance = 1'b1;
            control.alu_op = ALU_MOV;
            control.b_src = B_READ_DATA;
            control.alu_wb = WB_RD;
            control.mem_byte = decoded.b;
        end
    end

    // No clock reaches this stage, so the bus check is combinational
    always_comb begin
        a_one_mem_access: assert (!(control.mem_read && control.mem_write));
    end

endmodule

`default_nettype wire

// ==== source/branch_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_control (
    input  control_pkg::decoded_t decoded,
    input  control_pkg::step_t    step,
    output control_pkg::control_t control
);

    import control_pkg::*;

    logic target_step;
    logic link_step;

    assign target_step = (decoded.instr_class == BRANCH && step == 2'd0) ||
                         (decoded.instr_class == BRANCH_LINK && step == 2'd1);

    assign link_step = (decoded.instr_class == BRANCH_LINK && step == 2'd0);

    always_comb begin
        control = '0;
        if (target_step) begin
            // PC + (sign-extended offset << 2), sent out as the new address
            control.pipeline_advance = 1'b1;
            control.addr_src = ADDR_ALU;
            control.a_src = A_RN;
            control.b_src = B_IMM;
            control.b_imm = decoded.imm24;
            control.b_sign_extend = 1'b1;
            control.shift_type = LSL;
            control.shift_amt = 5'd2;
            control.alu_op = ALU_ADD;
            control.alu_wb = WB_RN;
        end else if (link_step) begin
            // Return address is the PC one word back
            control.a_src = A_RN;
            control.b_src = B_IMM;
            control.b_imm = 24'd4;
            control.alu_op = ALU_SUB;
            control.alu_wb = WB_R14;
        end
    end

endmodule

`default_nettype wire

// ==== source/arm_control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module arm_control_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush_req,
    input  logic                  condition_pass,
    input  control_pkg::word_t    instr,
    output control_pkg::control_t control
);

    import control_pkg::*;

    decoded_t     decoded;
    flush_phase_t phase;
    step_t        step;
    control_t     dp_control;
    control_t     xfer_control;
    control_t     br_control;

    // ==================================================
    // Stage chain
    // ==================================================

    instr_classifier u_instr_classifier (
        .instr   (instr),
        .decoded (decoded)
    );

    step_sequencer u_step_sequencer (
        .clk              (clk),
        .reset            (reset),
        .flush_req        (flush_req),
        .pipeline_advance (control.pipeline_advance),
        .phase            (phase),
        .step             (step)
    );

    dataproc_control u_dataproc_control (
        .decoded (decoded),
        .step    (step),
        .control (dp_control)
    );

    transfer_control u_transfer_control (
        .decoded (decoded),
        .step    (step),
        .control (xfer_control)
    );

    branch_control u_branch_control (
        .decoded (decoded),
        .step    (step),
        .control (br_control)
    );

    // Flush first, then the skip of a failed condition, then the class owner
    always_comb begin
        control = '0;
        case (phase)
            FLUSH_ADDR: begin
                control.addr_src = ADDR_PC;
            end
            FLUSH_FETCH: begin
                control = fetch_word();
                control.addr_src = ADDR_INCR;
            end
            FLUSH_ADVANCE: begin
                control = fetch_word();
                control.pipeline_advance = 1'b1;
            end
            default: begin
                if (!condition_pass) begin
                    control = fetch_word();
                    control.pipeline_advance = 1'b1;
                end else begin
                    case (decoded.instr_class)
                        DP_IMM, DP_REG_IMM, DP_REG_REG: control = dp_control;
                        LOAD, STORE:                    control = xfer_control;
                        BRANCH, BRANCH_LINK:            control = br_control;
                        default:                        control = '0;
                    endcase
                end
            end
        endcase
    end

    a_no_advance_on_addr: assert property (@(posedge clk) disable iff (reset)
        (phase == FLUSH_ADDR) |-> !control.pipeline_advance);

endmodule

`default_nettype wire

// ==== testbench/arm_control_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module arm_control_unit_tb;

    import control_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int SAMPLE_DELAY = 2;
    localparam int NUM_ROWS = 17;
    localparam logic [3:0] MAX_CYCLES = 4'd5;

    typedef struct packed {
        word_t        base;
        word_t        mask;       // Bits filled from the LFSR
        logic         cond;
        instr_class_t cls;
        logic [3:0]   cycles;     // Cycles from step 0 to advance
        alu_wb_t      final_wb;
    } test_row_t;

    logic     clk;
    logic     reset;
    logic     flush_req;
    logic     condition_pass;
    word_t    instr;
    control_t control;

    test_row_t   rows [NUM_ROWS];
    int          row_count;
    int          mismatch_count;
    int          failure_count;
    logic [31:0] lfsr_state;

    arm_control_unit u_arm_control_unit (
        .clk            (clk),
        .reset          (reset),
        .flush_req      (flush_req),
        .condition_pass (condition_pass),
        .instr          (instr),
        .control        (control)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (NUM_ROWS * 10 + 50) @(posedge clk);
        $display("Timeout: the test did not finish in time");
        $display("Something failed");
        $finish;
    end

    // ==================================================
    // Stimulus helpers
    // ==================================================

    // Taps 32, 22, 2, 1
    function automatic logic next_random_bit();
        logic feedback;
        feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    function automatic word_t randomize_fields(input word_t base, input word_t mask);
        word_t w;
        w = base;
        for (int b = 0; b < 32; b++) begin
            if (mask[b]) begin
                w[b] = next_random_bit();
            end
        end
        return w;
    endfunction

    task automatic add_row(input word_t base, input word_t mask, input logic cond,
                           input instr_class_t cls, input logic [3:0] cycles,
                           input alu_wb_t final_wb);
        rows[row_count] = '{base, mask, cond, cls, cycles, final_wb};
        row_count++;
    endtask

    task automatic load_table();
        row_count = 0;
        add_row(32'hE2900000, 32'h000FFFFF, 1'b1, DP_IMM,      4'd1, WB_RD);   // ADDS imm
        add_row(32'hE3500000, 32'h000FFFFF, 1'b1, DP_IMM,      4'd1, WB_NONE); // CMP imm
        add_row(32'hE0800000, 32'h000FFFEF, 1'b1, DP_REG_IMM,  4'd1, WB_RD);
        add_row(32'hE1A00060, 32'h0000F00F, 1'b1, DP_REG_IMM,  4'd1, WB_RD);   // MOV RRX
        add_row(32'hE0800010, 32'h000FFF6F, 1'b1, DP_REG_REG,  4'd2, WB_RD);
        add_row(32'hE08F001F, 32'h0000FF60, 1'b1, DP_REG_REG,  4'd2, WB_RD);   // Rn and Rm are PC
        add_row(32'hE1100010, 32'h000FFF6F, 1'b1, DP_REG_REG,  4'd2, WB_NONE); // TST
        add_row(32'hE5900000, 32'h000FFFFF, 1'b1, LOAD,        4'd3, WB_RD);
        add_row(32'hE6500000, 32'h000FFFEF, 1'b1, LOAD,        4'd3, WB_RD);   // Post, byte, sub
        add_row(32'hE5300000, 32'h000FFFFF, 1'b1, LOAD,        4'd3, WB_RD);   // Pre with W
        add_row(32'hE5800000, 32'h000FFFFF, 1'b1, STORE,       4'd2, WB_NONE);
        add_row(32'hE6C00000, 32'h000FFFEF, 1'b1, STORE,       4'd2, WB_RN);   // Post, byte
        add_row(32'hEA000000, 32'h00FFFFFF, 1'b1, BRANCH,      4'd1, WB_RN);
        add_row(32'hEB000000, 32'h00FFFFFF, 1'b1, BRANCH_LINK, 4'd2, WB_RN);
        add_row(32'hE0800010, 32'h000FFF6F, 1'b0, DP_REG_REG,  4'd1, WB_NONE);
        add_row(32'hE5900000, 32'h000FFFFF, 1'b0, LOAD,        4'd1, WB_NONE);
        add_row(32'hEB000000, 32'h00FFFFFF, 1'b0, BRANCH_LINK, 4'd1, WB_NONE);
    endtask

    // ==================================================
    // Reference model
    // ==================================================

    function automatic control_t fetch_control_word();
        control_t c;
        c = '0;
        c.addr_src = ADDR_PC;
        c.instr_fetch = 1'b1;
        c.incr_writeback = 1'b1;
        return c;
    endfunction

    // ROR by zero stands for RRX
    function automatic logic is_rrx(input word_t word);
        return (word[6:5] == 2'b11) && (word[11:7] == 5'd0);
    endfunction

    function automatic control_t expected_control(input instr_class_t cls, input word_t word,
                                                  input logic cond, input step_t step);
        control_t c;
        logic     base_wb;
        c = '0;
        base_wb = !word[24] || word[21];
        if (!cond) begin
            if (step == 2'd0) begin
                c = fetch_control_word();
                c.pipeline_advance = 1'b1;
            end
            return c;
        end
        case (cls)
            DP_IMM: begin
                c = fetch_control_word();
                c.pipeline_advance = 1'b1;
                c.b_src = B_IMM;
                c.b_imm = {16'd0, word[7:0]};
                c.shift_type = ROR;
                c.shift_amt = {word[11:8], 1'b0};
            end
            DP_REG_IMM: begin
                c = fetch_control_word();
                c.pipeline_advance = 1'b1;
                c.b_src = B_RM;
                c.shift_type = shift_type_t'(word[6:5]);
                c.shift_amt = word[11:7];
                c.shift_use_rrx = is_rrx(word);
            end
            DP_REG_REG: begin
                if (step == 2'd0) begin
                    c.b_src = B_RS;
                    c.shift_latch_amt = 1'b1;
                end else if (step == 2'd1) begin
                    c = fetch_control_word();
                    c.pipeline_advance = 1'b1;
                    c.b_src = B_RM;
                    c.shift_type = shift_type_t'(word[6:5]);
                    c.shift_use_latch = 1'b1;
                    c.pc_rn_add_4 = (word[19:16] == 4'hF);
                    c.pc_rm_add_4 = (word[3:0] == 4'hF);
                end
            end
            LOAD, STORE: begin
                if (step == 2'd0) begin
                    c = fetch_control_word();
                    c.addr_src = ADDR_ALU;
                    c.alu_op = word[23] ? ALU_ADD : ALU_SUB;
                    c.alu_disable_op_b = !word[24];
                    c.alu_latch_op_b = !word[24] || word[21];
                    if (word[25]) begin
                        c.b_src = B_RM;
                        c.shift_type = shift_type_t'(word[6:5]);
                        c.shift_amt = word[11:7];
                        c.shift_use_rrx = is_rrx(word);
                    end else begin
                        c.b_src = B_IMM;
                        c.b_imm = {12'd0, word[11:0]};
                    end
                end else if (step == 2'd1) begin
                    if (cls == LOAD) begin
                        c.mem_read = 1'b1;
                    end else begin
                        c = fetch_control_word();
                        c.pipeline_advance = 1'b1;
                        c.b_src = B_RD;
                        c.mem_write = 1'b1;
                    end
                    c.addr_src = ADDR_PC;
                    c.alu_op = word[23] ? ALU_ADD : ALU_SUB;
                    c.mem_byte = word[22];
                    c.alu_use_op_b_latch = base_wb;
                    c.alu_wb = base_wb ? WB_RN : WB_NONE;
                end else if (step == 2'd2 && cls == LOAD) begin
                    c = fetch_control_word();
                    c.pipeline_advance = 1'b1;
                    c.alu_op = ALU_MOV;
                    c.b_src = B_READ_DATA;
                    c.alu_wb = WB_RD;
                    c.mem_byte = word[22];
                end
            end
            BRANCH, BRANCH_LINK: begin
                if ((cls == BRANCH && step == 2'd0) || (cls == BRANCH_LINK && step == 2'd1)) begin
                    c.pipeline_advance = 1'b1;
                    c.addr_src = ADDR_ALU;
                    c.a_src = A_RN;
                    c.b_src = B_IMM;
                    c.b_imm = word[23:0];
                    c.b_sign_extend = 1'b1;
                    c.shift_type = LSL;
                    c.shift_amt = 5'd2;
                    c.alu_op = ALU_ADD;
                    c.alu_wb = WB_RN;
                end else if (cls == BRANCH_LINK && step == 2'd0) begin
                    // R14 gets Rn minus 4
                    c.a_src = A_RN;
                    c.b_src = B_IMM;
                    c.b_imm = 24'd4;
                    c.alu_op = ALU_SUB;
                    c.alu_wb = WB_R14;
                end
            end
            default: ;
        endcase
        // Data processing does its ALU work on the final step only
        if (c.pipeline_advance && (cls == DP_IMM || cls == DP_REG_IMM || cls == DP_REG_REG)) begin
            c.alu_op = word[24:21];
            c.alu_wb = (word[24:23] == 2'b10) ? WB_NONE : WB_RD;
            c.set_flags = word[20];
        end
        return c;
    endfunction

    // ==================================================
    // Checks and test sequences
    // ==================================================

    task automatic check_control(input control_t exp, input string what);
        assert (control === exp) else begin
            $display("MISMATCH control (%s): got %h expected %h", what, control, exp);
            mismatch_count++;
        end
    endtask

    task automatic run_row(input int idx);
        word_t      word;
        control_t   exp;
        control_t   final_word;
        logic [3:0] cycle_count;
        logic       advanced;
        @(negedge clk);
        word = randomize_fields(rows[idx].base, rows[idx].mask);
        instr = word;
        condition_pass = rows[idx].cond;
        cycle_count = 4'd0;
        advanced = 1'b0;
        final_word = '0;
        while (!advanced && cycle_count < MAX_CYCLES) begin
            if (cycle_count != 4'd0) begin
                @(negedge clk);
            end
            #(SAMPLE_DELAY);
            assert (u_arm_control_unit.decoded.instr_class == rows[idx].cls) else begin
                $display("MISMATCH instr_class (row %0d): got %h expected %h", idx,
                         u_arm_control_unit.decoded.instr_class, rows[idx].cls);
                mismatch_count++;
            end
            exp = expected_control(rows[idx].cls, word, rows[idx].cond, cycle_count[1:0]);
            check_control(exp, $sformatf("row %0d step %0d instr %h", idx, cycle_count, word));
            advanced = control.pipeline_advance;
            final_word = control;
            cycle_count = cycle_count + 4'd1;
        end
        if (!advanced) begin
            $display("Row %0d never advanced within %0d cycles", idx, MAX_CYCLES);
            failure_count++;
        end else begin
            assert (cycle_count == rows[idx].cycles) else begin
                $display("MISMATCH cycles (row %0d): got %h expected %h", idx, cycle_count,
                         rows[idx].cycles);
                mismatch_count++;
            end
            assert (final_word.alu_wb == rows[idx].final_wb) else begin
                $display("MISMATCH alu_wb (row %0d): got %h expected %h", idx,
                         final_word.alu_wb, rows[idx].final_wb);
                mismatch_count++;
            end
        end
    endtask

    // Undefined words idle until a flush request restarts the fetch
    task automatic run_undefined();
        control_t exp;
        control_t idle;
        idle = '0;
        @(negedge clk);
        instr = randomize_fields(32'hE8900000, 32'h000FFFFF);
        condition_pass = 1'b1;
        for (int k = 0; k < 8; k++) begin
            if (k != 0) begin
                @(negedge clk);
            end
            #(SAMPLE_DELAY);
            check_control(idle, $sformatf("undefined cycle %0d", k));
        end
        @(negedge clk);
        flush_req = 1'b1;
        #(SAMPLE_DELAY);
        exp = fetch_control_word();
        exp.addr_src = ADDR_INCR;
        check_control(exp, "flush request fetch");
        @(negedge clk);
        flush_req = 1'b0;
        #(SAMPLE_DELAY);
        exp = fetch_control_word();
        exp.pipeline_advance = 1'b1;
        check_control(exp, "flush request advance");
    endtask

    initial begin
        control_t exp;
        lfsr_state = 32'hc3bb;
        mismatch_count = 0;
        failure_count = 0;
        reset = 1'b1;
        flush_req = 1'b0;
        condition_pass = 1'b1;
        instr = '0;
        load_table();

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Flush sequence after reset, one phase per cycle
        #(SAMPLE_DELAY);
        exp = '0;
        exp.addr_src = ADDR_PC;
        check_control(exp, "reset flush address");
        @(negedge clk);
        #(SAMPLE_DELAY);
        exp = fetch_control_word();
        exp.addr_src = ADDR_INCR;
        check_control(exp, "reset flush fetch");
        @(negedge clk);
        #(SAMPLE_DELAY);
        exp = fetch_control_word();
        exp.pipeline_advance = 1'b1;
        check_control(exp, "reset flush advance");

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        run_undefined();

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
source/control_pkg.sv
source/instr_classifier.sv
source/step_sequencer.sv
source/dataproc_control.sv
source/transfer_control.sv
source/branch_control.sv
source/arm_control_unit.sv
testbench/arm_control_unit_tb.sv

// ==== Makefile ====
# Verilator simulation of the ARM control unit testbench

VERILATOR ?= verilator
TOP       ?= arm_control_unit_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Something failed" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	elif ! grep -q "Everything OK" $(LOG); then \
		echo "Simulation ended without a result (exit status $$status)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
